// File: source/kv_pkg.sv
/* key vault package with geometry, register map, flush patterns and vector types */
package kv_pkg;

    localparam int KV_NUM_KEYS = 8;
    localparam int KV_NUM_DWORDS = 12;
    localparam int KV_NUM_READ = 2;
    localparam int KV_NUM_WRITE = 2;
    localparam int KV_ENTRY_W = 3;
    localparam int KV_DWORD_W = 4;
    localparam int KV_ADDR_W = 8;
    localparam int KV_SIGNING_ENTRY = 7;

    typedef logic [31:0] kv_data_t;
    typedef logic [KV_ENTRY_W-1:0] kv_entry_t;
    typedef logic [KV_DWORD_W-1:0] kv_offset_t;
    typedef logic [KV_NUM_READ-1:0] kv_dest_t;
    typedef logic [KV_ADDR_W-1:0] kv_addr_t;

    // patterns loaded into the storage on a secret flush
    localparam kv_data_t KV_DEBUG_VALUE_0 = 32'haaaa_aaaa;
    localparam kv_data_t KV_DEBUG_VALUE_1 = 32'h5555_5555;

    // register map, KEY_CTRL of entry n sits at base + 4n
    localparam kv_addr_t KV_CTRL_BASE = 8'h00;
    localparam kv_addr_t KV_CLEAR_SECRETS_ADDR = 8'h40;

    localparam int KV_CTRL_LOCK_WR_BIT = 0;
    localparam int KV_CTRL_LOCK_USE_BIT = 1;
    localparam int KV_CTRL_CLEAR_BIT = 2;
    localparam int KV_CTRL_DEST_LSB = 8;
    localparam int KV_CTRL_LAST_LSB = 16;

    // CLEAR_SECRETS fields
    localparam int KV_CLR_WR_DEBUG_BIT = 0;
    localparam int KV_CLR_SEL_DEBUG_BIT = 1;

endpackage

// File: source/kv_bus_slave.sv
/* register bus slave, address decode and one-cycle acknowledge */
`timescale 1ns/1ps

module kv_bus_slave (
    input  logic             clk,
    input  logic             rst_b,
    input  logic             bus_req_i,
    input  logic             bus_we_i,
    input  kv_pkg::kv_addr_t bus_addr_i,
    input  kv_pkg::kv_data_t bus_wdata_i,
    input  kv_pkg::kv_data_t sw_rdata_i,
    input  logic             sw_wr_blocked_i,
    output logic             bus_ack_o,
    output logic             bus_err_o,
    output kv_pkg::kv_data_t bus_rdata_o,
    output logic             sw_wr_o,
    output logic             sw_rd_o,
    output logic             sw_sel_ctrl_o,
    output logic             sw_sel_clr_o,
    output kv_pkg::kv_entry_t sw_entry_o,
    output kv_pkg::kv_data_t sw_wdata_o
);

    kv_pkg::kv_addr_t ctrl_off;
    logic aligned;
    logic valid;
    logic ack_q;
    logic err_q;
    kv_pkg::kv_data_t rdata_q;

    // addresses below the base wrap around and miss the window
    assign ctrl_off = bus_addr_i - kv_pkg::KV_CTRL_BASE;
    assign aligned = (bus_addr_i[1:0] == 2'b00);

    assign sw_sel_ctrl_o = aligned &&
                           (ctrl_off < kv_pkg::kv_addr_t'(4 * kv_pkg::KV_NUM_KEYS));
    assign sw_sel_clr_o = (bus_addr_i == kv_pkg::KV_CLEAR_SECRETS_ADDR);
    assign sw_entry_o = ctrl_off[kv_pkg::KV_ENTRY_W+1:2];
    assign sw_wdata_o = bus_wdata_i;

    assign valid = bus_req_i & (sw_sel_ctrl_o | sw_sel_clr_o);
    assign sw_wr_o = valid & bus_we_i;
    assign sw_rd_o = valid & ~bus_we_i;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            rdata_q <= '0;
        end else begin
            ack_q <= bus_req_i;
            // unmapped, misaligned or lock-blocked accesses
            err_q <= bus_req_i & (~valid | sw_wr_blocked_i);
            rdata_q <= sw_rdata_i;
        end
    end

    assign bus_ack_o = ack_q;
    assign bus_err_o = err_q;
    assign bus_rdata_o = rdata_q;

endmodule

// File: source/kv_regs.sv
/* key storage, per-entry KEY_CTRL registers and the CLEAR_SECRETS register */
`timescale 1ns/1ps

module kv_regs (
    input  logic              clk,
    input  logic              rst_b,
    input  logic              sw_wr_i,
    input  logic              sw_rd_i,
    input  logic              sw_sel_ctrl_i,
    input  logic              sw_sel_clr_i,
    input  kv_pkg::kv_entry_t sw_entry_i,
    input  kv_pkg::kv_data_t  sw_wdata_i,
    input  logic [kv_pkg::KV_NUM_KEYS-1:0] lock_eff_i,
    input  logic [kv_pkg::KV_NUM_KEYS*kv_pkg::KV_NUM_DWORDS-1:0] dword_we_i,
    input  kv_pkg::kv_data_t [kv_pkg::KV_NUM_KEYS*kv_pkg::KV_NUM_DWORDS-1:0] dword_next_i,
    input  logic [kv_pkg::KV_NUM_KEYS-1:0] ctrl_we_i,
    input  kv_pkg::kv_dest_t [kv_pkg::KV_NUM_KEYS-1:0] dest_next_i,
    input  kv_pkg::kv_offset_t [kv_pkg::KV_NUM_KEYS-1:0] last_next_i,
    input  logic [kv_pkg::KV_NUM_KEYS-1:0] clear_i,
    output kv_pkg::kv_data_t  sw_rdata_o,
    output logic              sw_wr_blocked_o,
    output logic [kv_pkg::KV_NUM_KEYS-1:0] lock_wr_o,
    output logic [kv_pkg::KV_NUM_KEYS-1:0] lock_use_o,
    output logic [kv_pkg::KV_NUM_KEYS-1:0] clear_req_o,
    output kv_pkg::kv_dest_t [kv_pkg::KV_NUM_KEYS-1:0] dest_valid_o,
    output kv_pkg::kv_offset_t [kv_pkg::KV_NUM_KEYS-1:0] last_dword_o,
    output kv_pkg::kv_data_t [kv_pkg::KV_NUM_KEYS*kv_pkg::KV_NUM_DWORDS-1:0] key_data_o,
    output logic              clr_debug_wr_o,
    output logic              clr_sel_debug_o
);

    kv_pkg::kv_data_t [kv_pkg::KV_NUM_KEYS*kv_pkg::KV_NUM_DWORDS-1:0] key_q;
    logic [kv_pkg::KV_NUM_KEYS-1:0] lock_wr_q;
    logic [kv_pkg::KV_NUM_KEYS-1:0] lock_use_q;
    kv_pkg::kv_dest_t [kv_pkg::KV_NUM_KEYS-1:0] dest_q;
    kv_pkg::kv_offset_t [kv_pkg::KV_NUM_KEYS-1:0] last_q;
    logic clr_wr_q;
    logic clr_sel_q;
    logic ctrl_wr;
    logic ctrl_hit_wr;
    kv_pkg::kv_data_t ctrl_rdata;

    assign ctrl_hit_wr = sw_wr_i & sw_sel_ctrl_i;
    assign sw_wr_blocked_o = ctrl_hit_wr & lock_eff_i[sw_entry_i];
    assign ctrl_wr = ctrl_hit_wr & ~lock_eff_i[sw_entry_i];

    // locks are set-only, only rst_b brings them back down
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_wr_q <= '0;
            lock_use_q <= '0;
        end else if (ctrl_wr) begin
            lock_wr_q[sw_entry_i] <= lock_wr_q[sw_entry_i] |
                                     sw_wdata_i[kv_pkg::KV_CTRL_LOCK_WR_BIT];
            lock_use_q[sw_entry_i] <= lock_use_q[sw_entry_i] |
                                      sw_wdata_i[kv_pkg::KV_CTRL_LOCK_USE_BIT];
        end
    end

    always_comb begin
        clear_req_o = '0;
        if (ctrl_wr) begin
            clear_req_o[sw_entry_i] = sw_wdata_i[kv_pkg::KV_CTRL_CLEAR_BIT];
        end
    end

    // write-debug bit is a one-cycle pulse, select bit is held
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            clr_wr_q <= 1'b0;
            clr_sel_q <= 1'b0;
        end else begin
            clr_wr_q <= sw_wr_i & sw_sel_clr_i & sw_wdata_i[kv_pkg::KV_CLR_WR_DEBUG_BIT];
            if (sw_wr_i && sw_sel_clr_i) begin
                clr_sel_q <= sw_wdata_i[kv_pkg::KV_CLR_SEL_DEBUG_BIT];
            end
        end
    end

    // clear wins over any hardware write in the same cycle
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            key_q <= '0;
            dest_q <= '0;
            last_q <= '0;
        end else begin
            for (int i = 0; i < kv_pkg::KV_NUM_KEYS * kv_pkg::KV_NUM_DWORDS; i++) begin
                if (clear_i[i / kv_pkg::KV_NUM_DWORDS]) begin
                    key_q[i] <= '0;
                end else if (dword_we_i[i]) begin
                    key_q[i] <= dword_next_i[i];
                end
            end
            for (int e = 0; e < kv_pkg::KV_NUM_KEYS; e++) begin
                if (clear_i[e]) begin
                    dest_q[e] <= '0;
                    last_q[e] <= '0;
                end else if (ctrl_we_i[e]) begin
                    dest_q[e] <= dest_next_i[e];
                    last_q[e] <= last_next_i[e];
                end
            end
        end
    end

    // read-back, the clear bit always reads 0
    always_comb begin
        ctrl_rdata = '0;
        ctrl_rdata[kv_pkg::KV_CTRL_LOCK_WR_BIT] = lock_wr_q[sw_entry_i];
        ctrl_rdata[kv_pkg::KV_CTRL_LOCK_USE_BIT] = lock_use_q[sw_entry_i];
        ctrl_rdata[kv_pkg::KV_CTRL_DEST_LSB +: kv_pkg::KV_NUM_READ] = dest_q[sw_entry_i];
        ctrl_rdata[kv_pkg::KV_CTRL_LAST_LSB +: kv_pkg::KV_DWORD_W] = last_q[sw_entry_i];
        sw_rdata_o = '0;
        if (sw_rd_i && sw_sel_ctrl_i) begin
            sw_rdata_o = ctrl_rdata;
        end else if (sw_rd_i && sw_sel_clr_i) begin
            sw_rdata_o[kv_pkg::KV_CLR_SEL_DEBUG_BIT] = clr_sel_q;
        end
    end

    assign lock_wr_o = lock_wr_q;
    assign lock_use_o = lock_use_q;
    assign dest_valid_o = dest_q;
    assign last_dword_o = last_q;
    assign key_data_o = key_q;
    assign clr_debug_wr_o = clr_wr_q;
    assign clr_sel_debug_o = clr_sel_q;

endmodule

// File: source/kv_access_ctrl.sv
/* client write muxing, lock qualification, entry clear and permission-checked reads */
`timescale 1ns/1ps

module kv_access_ctrl (
    input  logic clk,
    input  logic rst_b,
    input  logic fw_upd_window_i,
    input  logic scan_mode_i,
    input  logic debug_unlock_i,
    input  logic [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_en_i,
    input  kv_pkg::kv_entry_t [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_entry_i,
    input  kv_pkg::kv_offset_t [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_offset_i,
    input  kv_pkg::kv_data_t [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_data_i,
    input  kv_pkg::kv_dest_t [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_dest_i,
    input  kv_pkg::kv_entry_t [kv_pkg::KV_NUM_READ-1:0] kv_rd_entry_i,
    input  kv_pkg::kv_offset_t [kv_pkg::KV_NUM_READ-1:0] kv_rd_offset_i,
    input  logic [kv_pkg::KV_NUM_KEYS-1:0] lock_wr_i,
    input  logic [kv_pkg::KV_NUM_KEYS-1:0] lock_use_i,
    input  logic [kv_pkg::KV_NUM_KEYS-1:0] clear_req_i,
    input  kv_pkg::kv_dest_t [kv_pkg::KV_NUM_KEYS-1:0] dest_valid_i,
    input  kv_pkg::kv_offset_t [kv_pkg::KV_NUM_KEYS-1:0] last_dword_i,
    input  kv_pkg::kv_data_t [kv_pkg::KV_NUM_KEYS*kv_pkg::KV_NUM_DWORDS-1:0] key_data_i,
    input  logic clr_debug_wr_i,
    input  logic clr_sel_debug_i,
    output logic [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_err_o,
    output kv_pkg::kv_data_t [kv_pkg::KV_NUM_READ-1:0] kv_rd_data_o,
    output logic [kv_pkg::KV_NUM_READ-1:0] kv_rd_err_o,
    output logic [kv_pkg::KV_NUM_READ-1:0] kv_rd_last_o,
    output kv_pkg::kv_data_t [kv_pkg::KV_NUM_DWORDS-1:0] signing_key_o,
    output logic [kv_pkg::KV_NUM_KEYS*kv_pkg::KV_NUM_DWORDS-1:0] dword_we_o,
    output kv_pkg::kv_data_t [kv_pkg::KV_NUM_KEYS*kv_pkg::KV_NUM_DWORDS-1:0] dword_next_o,
    output logic [kv_pkg::KV_NUM_KEYS-1:0] ctrl_we_o,
    output kv_pkg::kv_dest_t [kv_pkg::KV_NUM_KEYS-1:0] dest_next_o,
    output kv_pkg::kv_offset_t [kv_pkg::KV_NUM_KEYS-1:0] last_next_o,
    output logic [kv_pkg::KV_NUM_KEYS-1:0] clear_o,
    output logic [kv_pkg::KV_NUM_KEYS-1:0] lock_eff_o
);

    logic [kv_pkg::KV_NUM_KEYS-1:0] lock_use_eff;
    logic [kv_pkg::KV_NUM_KEYS-1:0] writable;
    logic [kv_pkg::KV_NUM_KEYS-1:0] hit;
    logic [kv_pkg::KV_NUM_KEYS-1:0] clear_q;
    kv_pkg::kv_data_t [kv_pkg::KV_NUM_KEYS-1:0] wdata_sel;
    kv_pkg::kv_data_t debug_value;
    logic flush;

    // locks only count outside the firmware update window
    assign lock_use_eff = lock_use_i & ~{kv_pkg::KV_NUM_KEYS{fw_upd_window_i}};
    assign lock_eff_o = (lock_wr_i & ~{kv_pkg::KV_NUM_KEYS{fw_upd_window_i}}) | lock_use_eff;
    assign writable = ~lock_eff_o | {kv_pkg::KV_NUM_KEYS{debug_unlock_i}};

    assign flush = debug_unlock_i | (scan_mode_i & clr_debug_wr_i);
    assign debug_value = clr_sel_debug_i ? kv_pkg::KV_DEBUG_VALUE_1 : kv_pkg::KV_DEBUG_VALUE_0;

    // walk clients downward so the lowest index wins a shared entry
    always_comb begin : client_mux
        hit = '0;
        wdata_sel = '0;
        dest_next_o = '0;
        last_next_o = '0;
        for (int e = 0; e < kv_pkg::KV_NUM_KEYS; e++) begin
            for (int c = kv_pkg::KV_NUM_WRITE - 1; c >= 0; c--) begin
                if (kv_wr_en_i[c] && kv_wr_entry_i[c] == kv_pkg::kv_entry_t'(e)) begin
                    hit[e] = 1'b1;
                    wdata_sel[e] = kv_wr_data_i[c];
                    dest_next_o[e] = kv_wr_dest_i[c];
                    last_next_o[e] = kv_wr_offset_i[c];
                end
            end
        end
    end

    assign ctrl_we_o = hit & writable;

    always_comb begin : dword_enables
        int idx;
        for (int e = 0; e < kv_pkg::KV_NUM_KEYS; e++) begin
            for (int d = 0; d < kv_pkg::KV_NUM_DWORDS; d++) begin
                idx = e * kv_pkg::KV_NUM_DWORDS + d;
                dword_we_o[idx] = writable[e] &
                                  (flush | (hit[e] & (last_next_o[e] == kv_pkg::kv_offset_t'(d))));
                dword_next_o[idx] = flush ? debug_value : wdata_sel[e];
            end
        end
    end

    // clear ignores locked entries and stretches while the entry is being written
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            clear_q <= '0;
        end else begin
            clear_q <= (clear_req_i & ~lock_eff_o) | (clear_q & hit);
        end
    end

    assign clear_o = clear_q;

    always_comb begin : write_resp
        for (int c = 0; c < kv_pkg::KV_NUM_WRITE; c++) begin
            kv_wr_err_o[c] = kv_wr_en_i[c] &
                             (clear_q[kv_wr_entry_i[c]] | lock_eff_o[kv_wr_entry_i[c]]);
        end
    end

    always_comb begin : read_mux
        logic rd_ok;
        for (int c = 0; c < kv_pkg::KV_NUM_READ; c++) begin
            rd_ok = ~lock_use_eff[kv_rd_entry_i[c]] & dest_valid_i[kv_rd_entry_i[c]][c];
            kv_rd_data_o[c] = '0;
            for (int d = 0; d < kv_pkg::KV_NUM_DWORDS; d++) begin
                if (rd_ok && kv_rd_offset_i[c] == kv_pkg::kv_offset_t'(d)) begin
                    kv_rd_data_o[c] = key_data_i[kv_rd_entry_i[c] * kv_pkg::KV_NUM_DWORDS + d];
                end
            end
            kv_rd_err_o[c] = ~rd_ok;
            kv_rd_last_o[c] = (kv_rd_offset_i[c] == last_dword_i[kv_rd_entry_i[c]]);
        end
    end

    always_comb begin : signing_key
        for (int d = 0; d < kv_pkg::KV_NUM_DWORDS; d++) begin
            signing_key_o[d] = key_data_i[kv_pkg::KV_SIGNING_ENTRY * kv_pkg::KV_NUM_DWORDS + d];
        end
    end

endmodule

// File: source/kv_top.sv
/* key vault top, bus slave plus register file plus access control */
`timescale 1ns/1ps

module kv_top (
    input  logic clk,
    input  logic rst_b,
    input  logic bus_req_i,
    input  logic bus_we_i,
    input  kv_pkg::kv_addr_t bus_addr_i,
    input  kv_pkg::kv_data_t bus_wdata_i,
    output logic bus_ack_o,
    output logic bus_err_o,
    output kv_pkg::kv_data_t bus_rdata_o,
    input  logic [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_en_i,
    input  kv_pkg::kv_entry_t [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_entry_i,
    input  kv_pkg::kv_offset_t [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_offset_i,
    input  kv_pkg::kv_data_t [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_data_i,
    input  kv_pkg::kv_dest_t [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_dest_i,
    output logic [kv_pkg::KV_NUM_WRITE-1:0] kv_wr_err_o,
    input  kv_pkg::kv_entry_t [kv_pkg::KV_NUM_READ-1:0] kv_rd_entry_i,
    input  kv_pkg::kv_offset_t [kv_pkg::KV_NUM_READ-1:0] kv_rd_offset_i,
    output kv_pkg::kv_data_t [kv_pkg::KV_NUM_READ-1:0] kv_rd_data_o,
    output logic [kv_pkg::KV_NUM_READ-1:0] kv_rd_err_o,
    output logic [kv_pkg::KV_NUM_READ-1:0] kv_rd_last_o,
    input  logic fw_upd_window_i,
    input  logic scan_mode_i,
    input  logic debug_unlock_i,
    output kv_pkg::kv_data_t [kv_pkg::KV_NUM_DWORDS-1:0] signing_key_o
);

    logic sw_wr;
    logic sw_rd;
    logic sw_sel_ctrl;
    logic sw_sel_clr;
    kv_pkg::kv_entry_t sw_entry;
    kv_pkg::kv_data_t sw_wdata;
    kv_pkg::kv_data_t sw_rdata;
    logic sw_wr_blocked;
    logic [kv_pkg::KV_NUM_KEYS-1:0] lock_eff;
    logic [kv_pkg::KV_NUM_KEYS-1:0] lock_wr;
    logic [kv_pkg::KV_NUM_KEYS-1:0] lock_use;
    logic [kv_pkg::KV_NUM_KEYS-1:0] clear_req;
    logic [kv_pkg::KV_NUM_KEYS-1:0] clear;
    logic [kv_pkg::KV_NUM_KEYS-1:0] ctrl_we;
    logic [kv_pkg::KV_NUM_KEYS*kv_pkg::KV_NUM_DWORDS-1:0] dword_we;
    kv_pkg::kv_data_t [kv_pkg::KV_NUM_KEYS*kv_pkg::KV_NUM_DWORDS-1:0] dword_next;
    kv_pkg::kv_data_t [kv_pkg::KV_NUM_KEYS*kv_pkg::KV_NUM_DWORDS-1:0] key_data;
    kv_pkg::kv_dest_t [kv_pkg::KV_NUM_KEYS-1:0] dest_next;
    kv_pkg::kv_dest_t [kv_pkg::KV_NUM_KEYS-1:0] dest_valid;
    kv_pkg::kv_offset_t [kv_pkg::KV_NUM_KEYS-1:0] last_next;
    kv_pkg::kv_offset_t [kv_pkg::KV_NUM_KEYS-1:0] last_dword;
    logic clr_debug_wr;
    logic clr_sel_debug;

    kv_bus_slave bus_slave_i (
        .clk(clk), .rst_b(rst_b),
        .bus_req_i(bus_req_i), .bus_we_i(bus_we_i),
        .bus_addr_i(bus_addr_i), .bus_wdata_i(bus_wdata_i),
        .sw_rdata_i(sw_rdata), .sw_wr_blocked_i(sw_wr_blocked),
        .bus_ack_o(bus_ack_o), .bus_err_o(bus_err_o), .bus_rdata_o(bus_rdata_o),
        .sw_wr_o(sw_wr), .sw_rd_o(sw_rd),
        .sw_sel_ctrl_o(sw_sel_ctrl), .sw_sel_clr_o(sw_sel_clr),
        .sw_entry_o(sw_entry), .sw_wdata_o(sw_wdata)
    );

    kv_regs regs_i (
        .clk(clk), .rst_b(rst_b),
        .sw_wr_i(sw_wr), .sw_rd_i(sw_rd),
        .sw_sel_ctrl_i(sw_sel_ctrl), .sw_sel_clr_i(sw_sel_clr),
        .sw_entry_i(sw_entry), .sw_wdata_i(sw_wdata),
        .lock_eff_i(lock_eff), .dword_we_i(dword_we), .dword_next_i(dword_next),
        .ctrl_we_i(ctrl_we), .dest_next_i(dest_next), .last_next_i(last_next),
        .clear_i(clear),
        .sw_rdata_o(sw_rdata), .sw_wr_blocked_o(sw_wr_blocked),
        .lock_wr_o(lock_wr), .lock_use_o(lock_use), .clear_req_o(clear_req),
        .dest_valid_o(dest_valid), .last_dword_o(last_dword), .key_data_o(key_data),
        .clr_debug_wr_o(clr_debug_wr), .clr_sel_debug_o(clr_sel_debug)
    );

    kv_access_ctrl access_ctrl_i (
        .clk(clk), .rst_b(rst_b),
        .fw_upd_window_i(fw_upd_window_i), .scan_mode_i(scan_mode_i),
        .debug_unlock_i(debug_unlock_i),
        .kv_wr_en_i(kv_wr_en_i), .kv_wr_entry_i(kv_wr_entry_i),
        .kv_wr_offset_i(kv_wr_offset_i), .kv_wr_data_i(kv_wr_data_i),
        .kv_wr_dest_i(kv_wr_dest_i),
        .kv_rd_entry_i(kv_rd_entry_i), .kv_rd_offset_i(kv_rd_offset_i),
        .lock_wr_i(lock_wr), .lock_use_i(lock_use), .clear_req_i(clear_req),
        .dest_valid_i(dest_valid), .last_dword_i(last_dword), .key_data_i(key_data),
        .clr_debug_wr_i(clr_debug_wr), .clr_sel_debug_i(clr_sel_debug),
        .kv_wr_err_o(kv_wr_err_o), .kv_rd_data_o(kv_rd_data_o),
        .kv_rd_err_o(kv_rd_err_o), .kv_rd_last_o(kv_rd_last_o),
        .signing_key_o(signing_key_o),
        .dword_we_o(dword_we), .dword_next_o(dword_next), .ctrl_we_o(ctrl_we),
        .dest_next_o(dest_next), .last_next_o(last_next),
        .clear_o(clear), .lock_eff_o(lock_eff)
    );

endmodule

// File: verif/kv_tb_clock.sv
/* testbench clock and reset generator */
`timescale 1ns/1ps

module kv_tb_clock #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_b_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset drops away on a falling edge
    initial begin
        rst_b_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_b_o = 1'b1;
    end

endmodule

// File: verif/kv_tb.sv
/* key vault testbench with shadow model, immediate and concurrent checks and a watchdog */
`timescale 1ns/1ps

module kv_tb;

    localparam int NK = kv_pkg::KV_NUM_KEYS;
    localparam int ND = kv_pkg::KV_NUM_DWORDS;
    localparam int NR = kv_pkg::KV_NUM_READ;
    localparam int NW = kv_pkg::KV_NUM_WRITE;
    localparam int RESET_CYCLES = 8;
    // five storage sweeps plus the bus, clear and lock sequences
    localparam int TEST_CYCLES = 5 * NK * ND + 100;
    localparam int WATCHDOG_NS = (RESET_CYCLES + TEST_CYCLES + 200) * 10;

    logic clk;
    logic rst_b;
    logic bus_req;
    logic bus_we;
    kv_pkg::kv_addr_t bus_addr;
    kv_pkg::kv_data_t bus_wdata;
    logic bus_ack;
    logic bus_err;
    kv_pkg::kv_data_t bus_rdata;
    logic [NW-1:0] wr_en;
    kv_pkg::kv_entry_t [NW-1:0] wr_entry;
    kv_pkg::kv_offset_t [NW-1:0] wr_offset;
    kv_pkg::kv_data_t [NW-1:0] wr_data;
    kv_pkg::kv_dest_t [NW-1:0] wr_dest;
    logic [NW-1:0] wr_err;
    kv_pkg::kv_entry_t [NR-1:0] rd_entry;
    kv_pkg::kv_offset_t [NR-1:0] rd_offset;
    kv_pkg::kv_data_t [NR-1:0] rd_data;
    logic [NR-1:0] rd_err;
    logic [NR-1:0] rd_last;
    logic fw_upd;
    logic scan_mode;
    logic debug_unlock;
    kv_pkg::kv_data_t [ND-1:0] signing_key;

    // shadow model of the vault
    kv_pkg::kv_data_t m_key [NK][ND];
    kv_pkg::kv_dest_t m_dest [NK];
    kv_pkg::kv_offset_t m_last [NK];
    logic [NK-1:0] m_lock_wr;
    logic [NK-1:0] m_lock_use;
    logic [NK-1:0] m_clr;
    logic m_flush_pend;
    logic m_sel;
    logic exp_ack;
    logic exp_err;
    kv_pkg::kv_data_t exp_rdata;
    logic [31:0] rng;
    int errors;

    kv_tb_clock #(.RESET_CYCLES(RESET_CYCLES)) clock_i (.clk_o(clk), .rst_b_o(rst_b));

    kv_top dut_i (
        .clk(clk), .rst_b(rst_b),
        .bus_req_i(bus_req), .bus_we_i(bus_we), .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata),
        .bus_ack_o(bus_ack), .bus_err_o(bus_err), .bus_rdata_o(bus_rdata),
        .kv_wr_en_i(wr_en), .kv_wr_entry_i(wr_entry), .kv_wr_offset_i(wr_offset),
        .kv_wr_data_i(wr_data), .kv_wr_dest_i(wr_dest), .kv_wr_err_o(wr_err),
        .kv_rd_entry_i(rd_entry), .kv_rd_offset_i(rd_offset),
        .kv_rd_data_o(rd_data), .kv_rd_err_o(rd_err), .kv_rd_last_o(rd_last),
        .fw_upd_window_i(fw_upd), .scan_mode_i(scan_mode), .debug_unlock_i(debug_unlock),
        .signing_key_o(signing_key)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at the first mismatch");
    endtask

    // ack one cycle after every request
    assert property (@(posedge clk) disable iff (!rst_b) bus_ack == exp_ack)
        else fail_value("bus_ack_o", $sampled(bus_ack), $sampled(exp_ack));

    for (genvar d = 0; d < ND; d++) begin : signing_chk
        assert property (@(posedge clk) disable iff (!rst_b)
                         signing_key[d] == m_key[kv_pkg::KV_SIGNING_ENTRY][d])
            else fail_value($sformatf("signing_key_o[%0d]", d), $sampled(signing_key[d]),
                            $sampled(m_key[kv_pkg::KV_SIGNING_ENTRY][d]));
    end

    // advanced on each rising edge from the inputs of the cycle that ends there
    task automatic model_edge();
        logic [NK-1:0] eff;
        logic [NK-1:0] clr_req;
        logic [NK-1:0] clr_next;
        logic ctrl_hit;
        logic clr_hit;
        logic flush;
        kv_pkg::kv_data_t dbg;
        int ent;
        int win;
        eff = (m_lock_wr | m_lock_use) & ~{NK{fw_upd}};
        flush = debug_unlock || (scan_mode && m_flush_pend);
        dbg = m_sel ? kv_pkg::KV_DEBUG_VALUE_1 : kv_pkg::KV_DEBUG_VALUE_0;
        ctrl_hit = (bus_addr[1:0] == 2'b00) &&
                   (kv_pkg::kv_addr_t'(bus_addr - kv_pkg::KV_CTRL_BASE) < 4 * NK);
        clr_hit = (bus_addr == kv_pkg::KV_CLEAR_SECRETS_ADDR);
        ent = (bus_addr - kv_pkg::KV_CTRL_BASE) >> 2;
        exp_ack = bus_req;
        exp_err = bus_req && (!(ctrl_hit || clr_hit) || (bus_we && ctrl_hit && eff[ent]));
        exp_rdata = '0;
        if (bus_req && !bus_we && ctrl_hit) begin
            exp_rdata[kv_pkg::KV_CTRL_LOCK_WR_BIT] = m_lock_wr[ent];
            exp_rdata[kv_pkg::KV_CTRL_LOCK_USE_BIT] = m_lock_use[ent];
            exp_rdata[kv_pkg::KV_CTRL_DEST_LSB +: NR] = m_dest[ent];
            exp_rdata[kv_pkg::KV_CTRL_LAST_LSB +: kv_pkg::KV_DWORD_W] = m_last[ent];
        end else if (bus_req && !bus_we && clr_hit) begin
            exp_rdata[1] = m_sel;
        end
        clr_req = '0;
        if (bus_req && bus_we && ctrl_hit && !eff[ent]) begin
            m_lock_wr[ent] = m_lock_wr[ent] | bus_wdata[kv_pkg::KV_CTRL_LOCK_WR_BIT];
            m_lock_use[ent] = m_lock_use[ent] | bus_wdata[kv_pkg::KV_CTRL_LOCK_USE_BIT];
            clr_req[ent] = bus_wdata[kv_pkg::KV_CTRL_CLEAR_BIT];
        end
        m_flush_pend = bus_req && bus_we && clr_hit && bus_wdata[0];
        if (bus_req && bus_we && clr_hit) begin
            m_sel = bus_wdata[1];
        end
        for (int e = 0; e < NK; e++) begin
            // lowest client index wins the entry
            win = -1;
            for (int c = NW - 1; c >= 0; c--) begin
                if (wr_en[c] && wr_entry[c] == e) begin
                    win = c;
                end
            end
            if (m_clr[e]) begin
                for (int d = 0; d < ND; d++) begin
                    m_key[e][d] = '0;
                end
                m_dest[e] = '0;
                m_last[e] = '0;
            end else if (!eff[e] || debug_unlock) begin
                for (int d = 0; d < ND; d++) begin
                    if (flush) begin
                        m_key[e][d] = dbg;
                    end else if (win >= 0 && wr_offset[win] == d) begin
                        m_key[e][d] = wr_data[win];
                    end
                end
                if (win >= 0) begin
                    m_dest[e] = wr_dest[win];
                    m_last[e] = wr_offset[win];
                end
            end
            clr_next[e] = (clr_req[e] && !eff[e]) || (m_clr[e] && win >= 0);
        end
        m_clr = clr_next;
    endtask

    task automatic check_outputs();
        int e;
        logic ok;
        logic flag;
        kv_pkg::kv_data_t val;
        for (int c = 0; c < NR; c++) begin
            e = rd_entry[c];
            ok = !(m_lock_use[e] && !fw_upd) && m_dest[e][c];
            val = ok ? m_key[e][rd_offset[c]] : '0;
            assert (rd_data[c] == val)
                else fail_value($sformatf("kv_rd_data_o[%0d]", c), rd_data[c], val);
            assert (rd_err[c] == !ok)
                else fail_value($sformatf("kv_rd_err_o[%0d]", c), rd_err[c], !ok);
            flag = (rd_offset[c] == m_last[e]);
            assert (rd_last[c] == flag)
                else fail_value($sformatf("kv_rd_last_o[%0d]", c), rd_last[c], flag);
        end
        for (int c = 0; c < NW; c++) begin
            e = wr_entry[c];
            flag = wr_en[c] && (m_clr[e] || ((m_lock_wr[e] || m_lock_use[e]) && !fw_upd));
            assert (wr_err[c] == flag)
                else fail_value($sformatf("kv_wr_err_o[%0d]", c), wr_err[c], flag);
        end
        if (exp_ack) begin
            assert (bus_err == exp_err) else fail_value("bus_err_o", bus_err, exp_err);
            assert (bus_rdata == exp_rdata) else fail_value("bus_rdata_o", bus_rdata, exp_rdata);
        end
    endtask

    // called on a falling edge with the inputs of the cycle already driven
    task automatic step_cycle();
        #1;
        check_outputs();
        @(posedge clk);
        model_edge();
        @(negedge clk);
    endtask

    task automatic bus_access(input logic we, input kv_pkg::kv_addr_t addr,
                              input kv_pkg::kv_data_t data);
        bus_req = 1'b1;
        bus_we = we;
        bus_addr = addr;
        bus_wdata = data;
        step_cycle();
        bus_req = 1'b0;
        step_cycle();
    endtask

    task automatic set_client_write(input int c, input int e, input int off,
                                    input kv_pkg::kv_data_t data, input kv_pkg::kv_dest_t dest);
        wr_en[c] = 1'b1;
        wr_entry[c] = kv_pkg::kv_entry_t'(e);
        wr_offset[c] = kv_pkg::kv_offset_t'(off);
        wr_data[c] = data;
        wr_dest[c] = dest;
    endtask

    task automatic pick_random_reads();
        for (int c = 0; c < NR; c++) begin
            rng = xorshift32(rng);
            rd_entry[c] = kv_pkg::kv_entry_t'(rng[2:0]);
            rd_offset[c] = kv_pkg::kv_offset_t'(rng[7:4] % ND);
        end
    endtask

    task automatic read_sweep(input int first, input int last);
        for (int e = first; e <= last; e++) begin
            for (int d = 0; d < ND; d++) begin
                rd_entry = {NR{kv_pkg::kv_entry_t'(e)}};
                rd_offset = {NR{kv_pkg::kv_offset_t'(d)}};
                step_cycle();
            end
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("error: watchdog expired after %0d ns without reaching the end", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin : stimulus
        kv_pkg::kv_dest_t dest;
        bus_req = 1'b0;
        bus_we = 1'b0;
        bus_addr = '0;
        bus_wdata = '0;
        wr_en = '0;
        wr_entry = '0;
        wr_offset = '0;
        wr_data = '0;
        wr_dest = '0;
        rd_entry = '0;
        rd_offset = '0;
        fw_upd = 1'b0;
        scan_mode = 1'b0;
        debug_unlock = 1'b0;
        m_key = '{default: '0};
        m_dest = '{default: '0};
        m_last = '{default: '0};
        m_lock_wr = '0;
        m_lock_use = '0;
        m_clr = '0;
        m_flush_pend = 1'b0;
        m_sel = 1'b0;
        exp_ack = 1'b0;
        exp_err = 1'b0;
        exp_rdata = '0;
        errors = 0;
        rng = 32'd70912;
        wait (rst_b === 1'b1);
        @(negedge clk);

        // random fill, readers wander over random entries meanwhile
        for (int e = 0; e < NK; e++) begin
            rng = xorshift32(rng);
            dest = rng[9:8];
            // entries 0 and 1 each grant a single reader
            if (e < 2) begin
                dest = kv_pkg::kv_dest_t'(e + 1);
            end
            for (int d = 0; d < ND; d++) begin
                rng = xorshift32(rng);
                set_client_write(rng[31], e, d, xorshift32(rng), dest);
                pick_random_reads();
                step_cycle();
                wr_en = '0;
            end
        end
        repeat (4) begin
            rng = xorshift32(rng);
            set_client_write(0, rng[2:0], rng[7:4] % ND, rng, 2'b11);
            set_client_write(1, rng[2:0], rng[11:8] % ND, ~rng, 2'b01);
            step_cycle();
            wr_en = '0;
        end
        read_sweep(0, NK - 1);

        // register bus reads, writes, unmapped and misaligned
        for (int e = 0; e < NK; e++) begin
            bus_access(1'b0, kv_pkg::kv_addr_t'(kv_pkg::KV_CTRL_BASE + 4 * e), '0);
        end
        bus_access(1'b0, kv_pkg::KV_CLEAR_SECRETS_ADDR, '0);
        bus_access(1'b1, 8'h00, 32'hffff_ff00);
        bus_access(1'b0, 8'h44, '0);
        bus_access(1'b1, 8'h80, 32'h7);
        bus_access(1'b0, 8'h06, '0);
        bus_access(1'b1, 8'h41, 32'h1);

        // clear entry 2 with a client write landing while the flag is up
        bus_req = 1'b1;
        bus_we = 1'b1;
        bus_addr = 8'h08;
        bus_wdata = 32'h4;
        step_cycle();
        bus_req = 1'b0;
        set_client_write(1, 2, 5, rng, 2'b11);
        step_cycle();
        wr_en = '0;
        step_cycle();
        read_sweep(2, 2);
        bus_access(1'b0, 8'h08, '0);

        // both readers may see entries 3 and 4 so the lock effects show on the data
        set_client_write(0, 3, 2, rng, 2'b11);
        set_client_write(1, 4, 6, ~rng, 2'b11);
        step_cycle();
        wr_en = '0;

        // write lock on entry 3, use lock on entry 4
        bus_access(1'b1, 8'h0c, 32'h1);
        bus_access(1'b1, 8'h10, 32'h2);
        bus_access(1'b0, 8'h0c, '0);
        bus_access(1'b0, 8'h10, '0);
        set_client_write(0, 3, 0, ~rng, 2'b11);
        step_cycle();
        wr_en = '0;
        read_sweep(3, 4);
        bus_access(1'b1, 8'h10, 32'h4);
        bus_access(1'b1, 8'h0c, 32'h0);
        fw_upd = 1'b1;
        set_client_write(0, 3, 1, rng ^ 32'h0f0f_0f0f, 2'b11);
        step_cycle();
        wr_en = '0;
        read_sweep(3, 4);
        fw_upd = 1'b0;

        // flush pulse outside scan mode does nothing
        bus_access(1'b1, kv_pkg::KV_CLEAR_SECRETS_ADDR, 32'h3);
        scan_mode = 1'b1;
        bus_access(1'b1, kv_pkg::KV_CLEAR_SECRETS_ADDR, 32'h3);
        scan_mode = 1'b0;
        bus_access(1'b0, kv_pkg::KV_CLEAR_SECRETS_ADDR, '0);
        read_sweep(0, NK - 1);
        scan_mode = 1'b1;
        bus_access(1'b1, kv_pkg::KV_CLEAR_SECRETS_ADDR, 32'h1);
        scan_mode = 1'b0;
        // debug unlock reaches the locked entries too
        debug_unlock = 1'b1;
        step_cycle();
        step_cycle();
        debug_unlock = 1'b0;
        fw_upd = 1'b1;
        read_sweep(0, NK - 1);
        fw_upd = 1'b0;
        step_cycle();

        if (errors == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: compile.f
source/kv_pkg.sv
source/kv_bus_slave.sv
source/kv_regs.sv
source/kv_access_ctrl.sv
source/kv_top.sv
verif/kv_tb_clock.sv
verif/kv_tb.sv
